//--- logic/mac_glue_pkg.sv
// Shared constants, bus structs and the SDRAM word union
// for the compact Mac glue logic
`default_nettype none

package mac_glue_pkg;

	// ==================================================
	// Counter sizes and hold times
	// ==================================================

	// Reset countdown, runs on the 8 MHz strobe
	localparam int RESET_CNT_W = 16;
	localparam logic [RESET_CNT_W-1:0] RESET_HOLD_COUNT = 16'hffff;

	// Disk light stretch, about 15 ms at the system clock
	localparam int DISK_ACT_CNT_W = 19;
	localparam logic [DISK_ACT_CNT_W-1:0] DISK_ACT_HOLD_CYCLES = 19'd500000;

	// ==================================================
	// Floppy image sizes and download slots
	// ==================================================

	// Image lengths count 16-bit words, not bytes
	localparam logic [23:0] DSK_DS_WORDS = 24'd409600;
	localparam logic [23:0] DSK_SS_WORDS = 24'd204800;

	// Loader index of the internal and external drive
	localparam logic [7:0] DISK_INT_INDEX = 8'd1;
	localparam logic [7:0] DISK_EXT_INDEX = 8'd2;

	// ==================================================
	// CPU bus decode
	// ==================================================

	// Top of the 24-bit address space holds the autovector area
	localparam logic [2:0] IO_SPACE_TOP = 3'b111;
	// Function code of an interrupt acknowledge cycle
	localparam logic [2:0] FC_INT_ACK = 3'b111;
	// ROM and downloaded images live in this SDRAM region
	localparam logic [3:0] SDRAM_ROM_BANK = 4'b0001;

	typedef logic [24:0] sdram_addr_t;
	typedef logic [21:0] mem_addr_t;

	// All sources that may hold the machine in reset
	typedef struct packed {
		logic pll_locked;
		logic osd_reset;
		logic user_button;
		logic ext_reset;
		logic cpu_reset_n;
	} reset_req_t;

	// Settings taken over while the reset counter runs
	typedef struct packed {
		logic       mem_4mb;
		logic [1:0] cpu_type;
		logic       model_se;
	} mac_config_t;

	typedef struct packed {
		logic       as_n;
		logic [2:0] fc;
		logic [2:0] addr_top;
	} cpu_bus_t;

	// Loader request toward the SDRAM port
	typedef struct packed {
		logic [20:0] addr;
		logic [15:0] data;
		logic        write;
	} dio_req_t;

	// SDRAM word, seen whole or as two bytes
	typedef union packed {
		logic [15:0] word;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
	} sdram_word_u;

	// Image class of one floppy drive
	typedef struct packed {
		logic ds;
		logic ss;
	} disk_state_t;

endpackage

`default_nettype wire

//--- logic/mac_glue_ctrl.sv
// System reset sequencing, configuration latch
// and CPU bus acknowledge generation
`timescale 1ns/10ps
`default_nettype none

module mac_glue_ctrl
	import mac_glue_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        rst_n,
	input  wire logic        clk8_en,
	input  wire reset_req_t  reset_req,
	input  wire mac_config_t status_cfg,
	input  wire logic        turbo,
	input  wire cpu_bus_t    cpu_bus,
	input  wire logic        cpu_bus_control,
	input  wire logic        select_rom,
	input  wire logic        select_ram,
	output logic             n_reset,
	output mac_config_t      cfg,
	output logic             vpa_n,
	output logic             dtack_n
);

	// ==================================================
	// Reset sequencing
	// ==================================================

	logic [RESET_CNT_W-1:0] rst_cnt;
	logic                   req_active;
	logic                   io_space;
	logic                   bus_ctl_d;
	logic                   bus_ctl_rise;
	logic                   turbo_dtack_en;

	// Any one source restarts the countdown
	assign req_active = ~reset_req.pll_locked
		| reset_req.osd_reset
		| reset_req.user_button
		| reset_req.ext_reset
		| ~reset_req.cpu_reset_n;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rst_cnt <= '1;
			n_reset <= 1'b0;
			cfg     <= '0;
		end else if (clk8_en) begin
			if (req_active) begin
				// Restart the hold and keep the machine down
				rst_cnt <= RESET_HOLD_COUNT;
				n_reset <= 1'b0;
			end else if (rst_cnt != '0) begin
				rst_cnt <= rst_cnt - 1'b1;
				// Settings follow the menu only while held in reset
				cfg     <= status_cfg;
			end else begin
				n_reset <= 1'b1;
			end
		end
	end

	// ==================================================
	// Bus acknowledge
	// ==================================================

	// Autovector and IO area at the top of the map
	assign io_space = (cpu_bus.addr_top == IO_SPACE_TOP);

	// Rising edge of real bus ownership
	assign bus_ctl_rise = cpu_bus_control & ~bus_ctl_d;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bus_ctl_d      <= 1'b0;
			turbo_dtack_en <= 1'b0;
		end else begin
			bus_ctl_d <= cpu_bus_control;
			if (!n_reset || cpu_bus.as_n) begin
				// Each bus cycle starts without an acknowledge
				turbo_dtack_en <= 1'b0;
			end else if (bus_ctl_rise || (!select_rom && !select_ram)) begin
				// Memory waits for its slot, anything else is acked at once
				turbo_dtack_en <= 1'b1;
			end
		end
	end

	// Interrupt acknowledge always takes the autovector
	always_comb begin
		if (cpu_bus.fc == FC_INT_ACK) begin
			vpa_n = 1'b0;
		end else begin
			vpa_n = ~(~cpu_bus.as_n & io_space);
		end
	end

	// Normal speed acks every memory cycle straight away
	// Turbo additionally waits for the registered enable
	assign dtack_n = ~(~cpu_bus.as_n & ~io_space) | (turbo & ~turbo_dtack_en);

endmodule

`default_nettype wire

//--- logic/image_loader.sv
// Download word latch, SDRAM address mapping and write pacing
// Floppy image size detection per drive
`timescale 1ns/10ps
`default_nettype none

module image_loader
	import mac_glue_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        rst_n,
	input  wire logic        ioctl_wr,
	input  wire logic [24:0] ioctl_addr,
	input  wire logic [15:0] ioctl_data,
	input  wire logic        dio_download,
	input  wire logic [7:0]  dio_index,
	input  wire logic        dio_bus_control,
	input  wire logic [1:0]  disk_eject,
	output dio_req_t         dio_req,
	output logic             ioctl_wait,
	output disk_state_t      disk_int,
	output disk_state_t      disk_ext,
	output logic [1:0]       disk_inserted
);

	logic [23:0] word_addr;
	logic [20:0] dio_addr;
	logic [15:0] dio_data;
	logic        dio_write;
	logic        bus_ctl_d;
	logic        dl_d;
	logic        dl_end;
	disk_state_t img_class;

	// Loader counts bytes, SDRAM counts words
	assign word_addr = ioctl_addr[24:1];

	// ==================================================
	// Download word path
	// ==================================================

	// Each loader write latches the swapped word and its SDRAM address
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr) begin
			// Host sends little endian, the 68k wants big endian
			dio_data <= {ioctl_data[7:0], ioctl_data[15:8]};
			if (dio_index[1:0] != 2'b00) begin
				// Floppy images go above the ROM at 0x80000 / 0x100000
				dio_addr <= {dio_index[1:0], word_addr[18:0]};
			end else begin
				// ROM, index bit 6 picks the upper half
				dio_addr <= {2'b00, dio_index[6], word_addr[17:0]};
			end
		end
	end

	// Wait flag and write strobe
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ioctl_wait <= 1'b0;
			dio_write  <= 1'b0;
			bus_ctl_d  <= 1'b0;
		end else begin
			if (ioctl_wr) begin
				ioctl_wait <= 1'b1;
			end
			bus_ctl_d <= dio_bus_control;
			// Strobe is armed outside the slot so it is stable inside it
			if (!dio_bus_control) begin
				dio_write <= ioctl_wait;
			end
			// Slot has ended with the write done
			if (bus_ctl_d && !dio_bus_control && dio_write) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	assign dio_req = '{addr: dio_addr, data: dio_data, write: dio_write};

	// ==================================================
	// Floppy image detection
	// ==================================================

	assign dl_end = dl_d & ~dio_download;

	// Length of the finished download decides the disk type
	assign img_class.ds = (word_addr == DSK_DS_WORDS);
	assign img_class.ss = (word_addr == DSK_SS_WORDS);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_d     <= 1'b0;
			disk_int <= '0;
			disk_ext <= '0;
		end else begin
			dl_d <= dio_download;
			if (dl_end && dio_index == DISK_INT_INDEX) begin
				disk_int <= img_class;
			end
			if (dl_end && dio_index == DISK_EXT_INDEX) begin
				disk_ext <= img_class;
			end
			// Guest eject wins over a download ending
			if (disk_eject[0]) begin
				disk_int <= '0;
			end
			if (disk_eject[1]) begin
				disk_ext <= '0;
			end
		end
	end

	// Any known image counts as inserted
	assign disk_inserted = {disk_ext.ds | disk_ext.ss, disk_int.ds | disk_int.ss};

endmodule

`default_nettype wire

//--- logic/sdram_port_mux.sv
// SDRAM request source select and region mapping
// Read data formatting toward the CPU
`timescale 1ns/10ps
`default_nettype none

module sdram_port_mux
	import mac_glue_pkg::*;
(
	input  wire logic        dio_download,
	input  wire logic        dio_bus_control,
	input  wire dio_req_t    dio_req,
	input  wire logic        model_se,
	input  wire mem_addr_t   mem_addr,
	input  wire logic        rom_oe_n,
	input  wire logic        ram_oe_n,
	input  wire logic        ram_we_n,
	input  wire logic        mem_uds_n,
	input  wire logic        mem_lds_n,
	input  wire logic [15:0] mem_data_out,
	input  wire logic        disk_ack_int,
	input  wire logic        disk_ack_ext,
	input  wire sdram_word_u sdram_out,
	output sdram_addr_t      sdram_addr,
	output logic [15:0]      sdram_din,
	output logic [1:0]       sdram_ds,
	output logic             sdram_we,
	output logic             sdram_oe,
	output logic [15:0]      cpu_mem_data
);

	logic        download_cycle;
	logic        disk_ack;
	sdram_word_u disk_word;

	// Loader owns the port in its own slot only
	assign download_cycle = dio_download & dio_bus_control;
	assign disk_ack       = disk_ack_int | disk_ack_ext;

	// ==================================================
	// Request select, download first then ROM then RAM
	// ==================================================
	always_comb begin
		if (download_cycle) begin
			sdram_addr = {SDRAM_ROM_BANK, dio_req.addr};
			sdram_din  = dio_req.data;
			sdram_ds   = 2'b11;
			sdram_we   = dio_req.write;
			sdram_oe   = 1'b0;
		end else begin
			if (!rom_oe_n) begin
				// Plus and SE ROMs sit side by side in the bank
				sdram_addr = {SDRAM_ROM_BANK, 2'b00, model_se, mem_addr[18:1]};
			end else begin
				// Disk reads land in the image area above RAM
				sdram_addr = {3'b000, disk_ack, mem_addr[21:1]};
			end
			sdram_din = mem_data_out;
			sdram_ds  = {~mem_uds_n, ~mem_lds_n};
			sdram_we  = ~ram_we_n;
			sdram_oe  = ~ram_oe_n | ~rom_oe_n | disk_ack;
		end
	end

	// Disk images are byte wide, odd address takes the low byte
	assign disk_word.bytes.hi = mem_addr[0] ? sdram_out.bytes.lo : sdram_out.bytes.hi;
	assign disk_word.bytes.lo = mem_addr[0] ? sdram_out.bytes.lo : sdram_out.bytes.hi;

	// Black screen during a download, all ones on the bus
	assign cpu_mem_data = download_cycle ? 16'hffff
		: disk_ack ? disk_word.word
		: sdram_out.word;

endmodule

`default_nettype wire

//--- logic/disk_activity_led.sv
// Disk access pulse stretcher and user LED
`timescale 1ns/10ps
`default_nettype none

module disk_activity_led
	import mac_glue_pkg::*;
(
	input  wire logic       clk_sys,
	input  wire logic       rst_n,
	input  wire logic [1:0] disk_act,
	input  wire logic [1:0] disk_motor,
	input  wire logic       dio_download,
	output logic            led_user
);

	logic [DISK_ACT_CNT_W-1:0] hold_cnt;
	logic                      activity;

	// Each access restarts the hold time
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hold_cnt <= '0;
		end else if (|disk_act) begin
			hold_cnt <= DISK_ACT_HOLD_CYCLES;
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	assign activity = (hold_cnt != '0);

	// Access blinks the light against the motor state
	// downloads keep it lit
	assign led_user = dio_download | (activity ^ (|disk_motor));

endmodule

`default_nettype wire

//--- logic/mac_glue_top.sv
// Top level of the Mac glue logic
// Reset and acknowledge control, image loader, SDRAM port mux, disk LED
`timescale 1ns/10ps
`default_nettype none

module mac_glue_top
	import mac_glue_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        rst_n,
	// Reset and configuration
	input  wire reset_req_t  reset_req,
	input  wire mac_config_t status_cfg,
	input  wire logic        turbo,
	input  wire logic        clk8_en,
	// CPU and address controller
	input  wire cpu_bus_t    cpu_bus,
	input  wire logic        cpu_bus_control,
	input  wire logic        select_rom,
	input  wire logic        select_ram,
	// Image download
	input  wire logic        ioctl_wr,
	input  wire logic [24:0] ioctl_addr,
	input  wire logic [15:0] ioctl_data,
	input  wire logic        dio_download,
	input  wire logic [7:0]  dio_index,
	input  wire logic        dio_bus_control,
	// Floppy drives
	input  wire logic [1:0]  disk_eject,
	input  wire logic [1:0]  disk_motor,
	input  wire logic [1:0]  disk_act,
	// Memory side
	input  wire mem_addr_t   mem_addr,
	input  wire logic        rom_oe_n,
	input  wire logic        ram_oe_n,
	input  wire logic        ram_we_n,
	input  wire logic        mem_uds_n,
	input  wire logic        mem_lds_n,
	input  wire logic [15:0] mem_data_out,
	input  wire logic        disk_ack_int,
	input  wire logic        disk_ack_ext,
	input  wire sdram_word_u sdram_out,
	output logic             n_reset,
	output mac_config_t      cfg,
	output logic             vpa_n,
	output logic             dtack_n,
	output logic             ioctl_wait,
	output disk_state_t      disk_int,
	output disk_state_t      disk_ext,
	output logic [1:0]       disk_inserted,
	output sdram_addr_t      sdram_addr,
	output logic [15:0]      sdram_din,
	output logic [1:0]       sdram_ds,
	output logic             sdram_we,
	output logic             sdram_oe,
	output logic [15:0]      cpu_mem_data,
	output logic             led_user
);

	// Loader request into the SDRAM port
	dio_req_t dio_req;

	mac_glue_ctrl i_ctrl (
		.clk_sys, .rst_n, .clk8_en, .reset_req, .status_cfg, .turbo,
		.cpu_bus, .cpu_bus_control, .select_rom, .select_ram,
		.n_reset, .cfg, .vpa_n, .dtack_n
	);

	image_loader i_loader (
		.clk_sys, .rst_n, .ioctl_wr, .ioctl_addr, .ioctl_data,
		.dio_download, .dio_index, .dio_bus_control, .disk_eject,
		.dio_req, .ioctl_wait, .disk_int, .disk_ext, .disk_inserted
	);

	// ROM half is picked by the latched model switch
	sdram_port_mux i_mux (
		.dio_download, .dio_bus_control, .dio_req, .model_se(cfg.model_se),
		.mem_addr, .rom_oe_n, .ram_oe_n, .ram_we_n, .mem_uds_n, .mem_lds_n,
		.mem_data_out, .disk_ack_int, .disk_ack_ext, .sdram_out,
		.sdram_addr, .sdram_din, .sdram_ds, .sdram_we, .sdram_oe, .cpu_mem_data
	);

	disk_activity_led i_led (
		.clk_sys, .rst_n, .disk_act, .disk_motor, .dio_download, .led_user
	);

endmodule

`default_nettype wire

//--- test/tb_mac_glue.sv
// Testbench for the Mac glue top level
// Case file driven stimulus, typed compare tasks and a watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_mac_glue
	import mac_glue_pkg::*;
();

	logic        clk_sys;
	logic        rst_n;
	reset_req_t  reset_req;
	mac_config_t status_cfg;
	logic        turbo;
	logic        clk8_en;
	cpu_bus_t    cpu_bus;
	logic        cpu_bus_control;
	logic        select_rom;
	logic        select_ram;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_data;
	logic        dio_download;
	logic [7:0]  dio_index;
	logic        dio_bus_control;
	logic [1:0]  disk_eject;
	logic [1:0]  disk_motor;
	logic [1:0]  disk_act;
	mem_addr_t   mem_addr;
	logic        rom_oe_n;
	logic        ram_oe_n;
	logic        ram_we_n;
	logic        mem_uds_n;
	logic        mem_lds_n;
	logic [15:0] mem_data_out;
	logic        disk_ack_int;
	logic        disk_ack_ext;
	sdram_word_u sdram_out;
	logic        n_reset;
	mac_config_t cfg;
	logic        vpa_n;
	logic        dtack_n;
	logic        ioctl_wait;
	disk_state_t disk_int;
	disk_state_t disk_ext;
	logic [1:0]  disk_inserted;
	sdram_addr_t sdram_addr;
	logic [15:0] sdram_din;
	logic [1:0]  sdram_ds;
	logic        sdram_we;
	logic        sdram_oe;
	logic [15:0] cpu_mem_data;
	logic        led_user;

	// Cases as read from the file, six hex arguments per case
	string       case_name[$];
	string       case_op[$];
	logic [31:0] case_arg[$];
	int          watchdog_cycles = 0;

	mac_glue_top i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Failure reporting and compare tasks
	// ==================================================
	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_logic(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_bits(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp)
			stop_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_cfg(input string name, input mac_config_t exp, input mac_config_t act);
		if (act !== exp)
			stop_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_disk(input string name, input disk_state_t exp, input disk_state_t act);
		if (act !== exp)
			stop_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_addr(input string name, input sdram_addr_t exp, input sdram_addr_t act);
		if (act !== exp)
			stop_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_word(input string name, input sdram_word_u exp, input sdram_word_u act);
		if (act.word !== exp.word)
			stop_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp.word, act.word));
	endtask

	// ==================================================
	// Case file and timing budget
	// ==================================================
	task automatic load_cases();
		int          fd;
		int          n;
		string       line;
		string       nm;
		string       op;
		logic [31:0] a0, a1, a2, a3, a4, a5;
		fd = $fopen("test/mac_glue_cases.txt", "r");
		if (fd == 0)
			stop_run("Could not open the case file test/mac_glue_cases.txt");
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			// Comment lines start with a hash
			if (n > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%s %s %h %h %h %h %h %h", nm, op, a0, a1, a2, a3, a4, a5);
				if (n == 8) begin
					case_name.push_back(nm);
					case_op.push_back(op);
					case_arg.push_back(a0);
					case_arg.push_back(a1);
					case_arg.push_back(a2);
					case_arg.push_back(a3);
					case_arg.push_back(a4);
					case_arg.push_back(a5);
				end
			end
		end
		$fclose(fd);
		if (case_name.size() == 0)
			stop_run("The case file holds no cases");
	endtask

	// Rough length of one case in clock cycles
	function automatic int case_cycles(input string op);
		if (op == "RST")
			return int'(RESET_HOLD_COUNT) + 16;
		else if (op == "LED")
			return int'(DISK_ACT_HOLD_CYCLES) + 16;
		else
			return 16;
	endfunction

	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk_sys);
		stop_run("The run timed out before all cases finished");
	end

	// ==================================================
	// Case steps, each starts on a falling edge
	// ==================================================

	// Request, release, count strobes, then change the switches
	task automatic run_rst(input string nm, input logic [31:0] a, b, c);
		reset_req.pll_locked = 1'b0;
		status_cfg = a[3:0];
		repeat (3) @(negedge clk_sys);
		check_logic({nm, " n_reset held"}, 1'b0, n_reset);
		reset_req.pll_locked = 1'b1;
		repeat (int'(RESET_HOLD_COUNT)) @(negedge clk_sys);
		check_logic({nm, " n_reset before release"}, 1'b0, n_reset);
		@(negedge clk_sys);
		check_logic({nm, " n_reset after release"}, 1'b1, n_reset);
		status_cfg = b[3:0];
		repeat (4) @(negedge clk_sys);
		check_cfg({nm, " cfg"}, c[3:0], cfg);
	endtask

	// Bus state, then sample after d clocks or at once
	task automatic run_bus(input string nm, input logic [31:0] a, b, c, d);
		turbo = a[3];
		cpu_bus_control = a[2];
		select_rom = a[1];
		select_ram = a[0];
		cpu_bus = b[6:0];
		if (d == 0)
			#5;
		else
			repeat (d) @(negedge clk_sys);
		check_logic({nm, " vpa_n"}, c[1], vpa_n);
		check_logic({nm, " dtack_n"}, c[0], dtack_n);
	endtask

	// One loader word through a full download slot
	task automatic run_dl(input string nm, input logic [31:0] a, b, c, d, e);
		int wait_cnt;
		dio_download = 1'b1;
		dio_bus_control = 1'b0;
		dio_index = a[7:0];
		ioctl_addr = b[24:0];
		ioctl_data = c[15:0];
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		repeat (2) @(negedge clk_sys);
		dio_bus_control = 1'b1;
		@(negedge clk_sys);
		check_logic({nm, " ioctl_wait"}, 1'b1, ioctl_wait);
		check_addr({nm, " sdram_addr"}, d[24:0], sdram_addr);
		check_word({nm, " sdram_din"}, e[15:0], sdram_word_u'(sdram_din));
		check_logic({nm, " sdram_we"}, 1'b1, sdram_we);
		check_logic({nm, " sdram_oe"}, 1'b0, sdram_oe);
		check_bits({nm, " sdram_ds"}, 2'b11, sdram_ds);
		// CPU sees all ones while the loader owns the port
		check_word({nm, " cpu_mem_data"}, 16'hffff, sdram_word_u'(cpu_mem_data));
		dio_bus_control = 1'b0;
		wait_cnt = 0;
		while (ioctl_wait && wait_cnt < 10) begin
			@(negedge clk_sys);
			wait_cnt++;
		end
		if (ioctl_wait)
			stop_run({nm, ": ioctl_wait did not fall after the download slot"});
		@(negedge clk_sys);
	endtask

	// End a download with the given last byte address
	task automatic run_flop(input string nm, input logic [31:0] a, b, c, d);
		dio_bus_control = 1'b0;
		dio_index = a[7:0];
		ioctl_addr = b[24:0];
		dio_download = 1'b1;
		repeat (2) @(negedge clk_sys);
		dio_download = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_disk({nm, " disk_int"}, c[1:0], disk_int);
		check_disk({nm, " disk_ext"}, c[3:2], disk_ext);
		check_bits({nm, " disk_inserted"}, d[1:0], disk_inserted);
	endtask

	task automatic run_eject(input string nm, input logic [31:0] a, c, d);
		disk_eject = a[1:0];
		@(negedge clk_sys);
		disk_eject = 2'b00;
		@(negedge clk_sys);
		check_disk({nm, " disk_int"}, c[1:0], disk_int);
		check_disk({nm, " disk_ext"}, c[3:2], disk_ext);
		check_bits({nm, " disk_inserted"}, d[1:0], disk_inserted);
	endtask

	// CPU side access, b packs the strobes and disk acks
	task automatic run_mem(input string nm, input logic [31:0] a, b, c, d, e, f);
		dio_download = 1'b0;
		dio_bus_control = 1'b0;
		mem_addr = a[21:0];
		{rom_oe_n, ram_oe_n, ram_we_n, mem_uds_n, mem_lds_n} = b[6:2];
		{disk_ack_int, disk_ack_ext} = b[1:0];
		sdram_out = c[15:0];
		#5;
		check_addr({nm, " sdram_addr"}, d[24:0], sdram_addr);
		check_word({nm, " cpu_mem_data"}, e[15:0], sdram_word_u'(cpu_mem_data));
		check_logic({nm, " sdram_we"}, f[3], sdram_we);
		check_logic({nm, " sdram_oe"}, f[2], sdram_oe);
		check_bits({nm, " sdram_ds"}, f[1:0], sdram_ds);
	endtask

	// Activity pulse, then watch the light across the hold time
	task automatic run_led(input string nm, input logic [31:0] a, b, c, d, e);
		dio_index = 8'd0;
		disk_motor = b[1:0];
		dio_download = e[0];
		disk_act = a[1:0];
		@(negedge clk_sys);
		disk_act = 2'b00;
		@(negedge clk_sys);
		check_logic({nm, " led after pulse"}, c[0], led_user);
		repeat (int'(DISK_ACT_HOLD_CYCLES) - 20) @(negedge clk_sys);
		check_logic({nm, " led near hold end"}, c[0], led_user);
		repeat (40) @(negedge clk_sys);
		check_logic({nm, " led after hold"}, d[0], led_user);
		disk_motor = 2'b00;
		dio_download = 1'b0;
	endtask

	task automatic run_case(input int idx);
		string       nm;
		string       op;
		logic [31:0] a[6];
		nm = case_name[idx];
		op = case_op[idx];
		for (int k = 0; k < 6; k++)
			a[k] = case_arg[idx*6 + k];
		if (op == "RST")
			run_rst(nm, a[0], a[1], a[2]);
		else if (op == "BUS")
			run_bus(nm, a[0], a[1], a[2], a[3]);
		else if (op == "DL")
			run_dl(nm, a[0], a[1], a[2], a[3], a[4]);
		else if (op == "FLOP")
			run_flop(nm, a[0], a[1], a[2], a[3]);
		else if (op == "EJECT")
			run_eject(nm, a[0], a[2], a[3]);
		else if (op == "MEM")
			run_mem(nm, a[0], a[1], a[2], a[3], a[4], a[5]);
		else if (op == "LED")
			run_led(nm, a[0], a[1], a[2], a[3], a[4]);
		else
			stop_run({"Unknown step kind in case ", nm});
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		int total;
		rst_n = 1'b0;
		// PLL locked, CPU out of reset, no other request
		reset_req = 5'b10001;
		status_cfg = '0;
		turbo = 1'b0;
		clk8_en = 1'b1;
		cpu_bus = 7'h40;
		cpu_bus_control = 1'b0;
		select_rom = 1'b0;
		select_ram = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_data = '0;
		dio_download = 1'b0;
		dio_index = '0;
		dio_bus_control = 1'b0;
		disk_eject = '0;
		disk_motor = '0;
		disk_act = '0;
		mem_addr = '0;
		rom_oe_n = 1'b1;
		ram_oe_n = 1'b1;
		ram_we_n = 1'b1;
		mem_uds_n = 1'b1;
		mem_lds_n = 1'b1;
		mem_data_out = '0;
		disk_ack_int = 1'b0;
		disk_ack_ext = 1'b0;
		sdram_out = '0;
		load_cases();
		total = 0;
		foreach (case_op[i])
			total += case_cycles(case_op[i]);
		watchdog_cycles = total + int'(RESET_HOLD_COUNT)
			+ 2 * int'(DISK_ACT_HOLD_CYCLES) + 1000;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		foreach (case_name[i]) begin
			@(negedge clk_sys);
			run_case(i);
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/mac_glue_cases.txt
# name kind a b c d e f (hex); RST cfg,later,exp  BUS ctl,bus,{vpa,dtack},clocks
# DL idx,addr,data,addr,din  FLOP idx,addr,{ext,int},ins  MEM addr,strb,out,addr,data,{we,oe,ds}
rst_plus RST 6 9 6 0 0 0
rom_plus MEM 2abcde 30 1357 215e6f 1357 7
bus_idle BUS 0 40 3 1 0 0
bus_io BUS 0 2f 1 0 0 0
bus_mem BUS 0 2a 2 0 0 0
bus_intack BUS 0 3f 1 0 0 0
bus_intack_noas BUS 0 7f 1 0 0 0
turbo_idle BUS a 40 3 1 0 0
turbo_rom_wait BUS a 2a 3 2 0 0
turbo_rom_own BUS e 2a 3 0 0 0
turbo_rom_dtack BUS e 2a 2 1 0 0
turbo_rom_end BUS e 6a 3 1 0 0
turbo_rom_again BUS e 2a 3 1 0 0
turbo_io_idle BUS 8 40 3 1 0 0
turbo_io_first BUS 8 2a 3 0 0 0
turbo_io_dtack BUS 8 2a 2 1 0 0
normal_idle BUS 0 40 3 1 0 0
dl_rom_lo DL 0 abcde a55a 215e6f 5aa5 0
dl_rom_hi DL 40 abcde 1234 255e6f 3412 0
dl_int DL 1 abcde beef 2d5e6f efbe 0
dl_ext DL 2 abcde 00ff 355e6f ff00 0
flop_int_ds FLOP 1 c8000 2 1 0 0
flop_ext_ss FLOP 2 64000 6 3 0 0
flop_int_other FLOP 1 1000 4 2 0 0
flop_ext_ds FLOP 2 c8000 8 2 0 0
flop_int_ss FLOP 1 64000 9 3 0 0
flop_ext_other FLOP 2 2 1 1 0 0
flop_int_ds2 FLOP 1 c8000 2 1 0 0
flop_ext_ss2 FLOP 2 64000 6 3 0 0
eject_int EJECT 1 0 4 2 0 0
eject_ext EJECT 2 0 0 0 0 0
rst_se RST b 0 b 0 0 0
rom_se MEM 2abcde 30 1357 255e6f 1357 7
ram_rd MEM 2abcde 54 1357 155e6f 1357 6
ram_wr MEM 2abcde 60 1357 155e6f 1357 b
disk_even MEM 2abcde 7e 1357 355e6f 1313 4
disk_odd MEM 2abcdf 7d 1357 355e6f 5757 4
led_blink LED 1 0 1 0 0 0
led_motor LED 2 1 0 1 0 0
led_download LED 1 0 1 1 1 0

//--- files.f
logic/mac_glue_pkg.sv
logic/mac_glue_ctrl.sv
logic/image_loader.sv
logic/sdram_port_mux.sv
logic/disk_activity_led.sv
logic/mac_glue_top.sv
test/tb_mac_glue.sv

//--- Bender.yml
package:
  name: mac_glue

sources:
  - logic/mac_glue_pkg.sv
  - logic/mac_glue_ctrl.sv
  - logic/image_loader.sv
  - logic/sdram_port_mux.sv
  - logic/disk_activity_led.sv
  - logic/mac_glue_top.sv
  - target: test
    files:
      - test/tb_mac_glue.sv
